// File: all.f
lsu_pkg.sv
ram_write_if.sv
stdmacro_dffbe.sv
common_dffram_2a1wb1r.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_scratchpad.sv
tb_clock_gen.sv
tb_lsu_scratchpad.sv

// File: common_dffram_2a1wb1r.sv
// Flip-flop RAM, one bit-masked write port and one combinational read port; RAM_DATA_WIDTH must equal XLEN
`timescale 1ns/1ps

module common_dffram_2a1wb1r
    import lsu_pkg::*;
#(
    parameter int RAM_DATA_WIDTH = 64,
    parameter int RAM_ADDR_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    ram_write_if.sink                   wr,
    input  logic [RAM_ADDR_WIDTH - 1:0] addrb,
    // Reserved for power-saving variants and does not gate the read
    input  logic                        enb,
    output xlen_t                       doutb
);

    localparam int RAM_DEPTH = 1 << RAM_ADDR_WIDTH;

    logic [RAM_DATA_WIDTH - 1:0] row_q [RAM_DEPTH];

    genvar i;
    generate
        for (i = 0; i < RAM_DEPTH; i++) begin : g_row
            logic [RAM_DATA_WIDTH - 1:0] row_we;
            logic                        row_sel;

            // Row is written only when enabled and addressed
            assign row_sel = wr.en && (wr.addr == RAM_ADDR_WIDTH'(i));
            assign row_we  = wr.mask & {RAM_DATA_WIDTH{row_sel}};

            stdmacro_dffbe #(
                .DFF_WIDTH (RAM_DATA_WIDTH)
            ) u_row (
                .clk   (clk),
                .rst_n (rst_n),
                .en    (row_we),
                .d     (wr.data),
                .q     (row_q[i])
            );
        end
    endgenerate

    assign doutb = row_q[addrb];

endmodule

// File: lsu_load_align.sv
// Load aligner; result and flags are registered and last one cycle, misaligned loads return zero
`timescale 1ns/1ps

module lsu_load_align
    import lsu_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [RAM_ADDR_WIDTH + 2:0] addr,
    input  access_size_t                size,
    input  logic                        is_unsigned,
    input  logic                        valid,
    output logic [RAM_ADDR_WIDTH - 1:0] rd_index,
    output logic                        rd_en,
    input  xlen_t                       rd_word,
    output xlen_t                       data,
    output logic                        data_valid,
    output logic                        misaligned
);

    logic [2:0] offset;
    logic       bad_align;
    xlen_t      shifted;
    xlen_t      extended;

    assign offset    = addr[2:0];
    assign bad_align = is_misaligned(size, offset);

    // Read the addressed doubleword in the same cycle as the strobe
    assign rd_index = addr[RAM_ADDR_WIDTH + 2:3];
    assign rd_en    = valid;

    // Move the addressed bytes down to lane zero
    assign shifted = rd_word >> {offset, 3'b000};

    always_comb begin
        case (size)
            SIZE_B: begin
                extended = {{56{~is_unsigned & shifted[7]}}, shifted[7:0]};
            end
            SIZE_H: begin
                extended = {{48{~is_unsigned & shifted[15]}}, shifted[15:0]};
            end
            SIZE_W: begin
                extended = {{32{~is_unsigned & shifted[31]}}, shifted[31:0]};
            end
            default: begin
                extended = shifted;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data       <= '0;
            data_valid <= 1'b0;
            misaligned <= 1'b0;
        end else begin
            data_valid <= valid;
            misaligned <= valid & bad_align;
            // Zero outside the result pulse and on a refused load
            data       <= (valid && !bad_align) ? extended : '0;
        end
    end

endmodule

// File: lsu_pkg.sv
// Shared LSU types for a 64-bit core; byte_addr_t assumes the default depth of 16 doublewords
package lsu_pkg;

    localparam int XLEN = 64;

    // Default RAM depth in index bits, used only to size byte_addr_t
    localparam int DEF_RAM_ADDR_WIDTH = 4;

    typedef logic [XLEN - 1:0]               xlen_t;
    typedef logic [XLEN - 1:0]               bit_mask_t;
    typedef logic [DEF_RAM_ADDR_WIDTH + 2:0] byte_addr_t;
    typedef logic [1:0]                      access_size_t;

    // Access size codes
    localparam access_size_t SIZE_B = 2'd0;
    localparam access_size_t SIZE_H = 2'd1;
    localparam access_size_t SIZE_W = 2'd2;
    localparam access_size_t SIZE_D = 2'd3;

    // Natural alignment check on the byte offset within a doubleword
    function automatic logic is_misaligned(access_size_t size, logic [2:0] offset);
        case (size)
            SIZE_H:  return offset[0];
            SIZE_W:  return |offset[1:0];
            SIZE_D:  return |offset;
            default: return 1'b0;
        endcase
    endfunction

endpackage

// File: lsu_scratchpad.sv
// Data scratchpad top; a load and store in the same cycle to one doubleword reads the old data
`timescale 1ns/1ps

module lsu_scratchpad
    import lsu_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // Store side, written on the edge that samples store_valid
    input  logic                        store_valid,
    input  logic [RAM_ADDR_WIDTH + 2:0] store_addr,
    input  access_size_t                store_size,
    input  xlen_t                       store_data,
    output logic                        store_misaligned,

    // Load side, result one cycle after load_valid
    input  logic                        load_valid,
    input  logic [RAM_ADDR_WIDTH + 2:0] load_addr,
    input  access_size_t                load_size,
    input  logic                        load_unsigned,
    output xlen_t                       load_data,
    output logic                        load_data_valid,
    output logic                        load_misaligned
);

    logic [RAM_ADDR_WIDTH - 1:0] rd_index;
    logic                        rd_en;
    xlen_t                       rd_word;

    ram_write_if #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) wr_bus ();

    lsu_store_align #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_store_align (
        .addr       (store_addr),
        .size       (store_size),
        .wdata      (store_data),
        .valid      (store_valid),
        .misaligned (store_misaligned),
        .wr         (wr_bus.source)
    );

    common_dffram_2a1wb1r #(
        .RAM_DATA_WIDTH (XLEN),
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr_bus.sink),
        .addrb (rd_index),
        .enb   (rd_en),
        .doutb (rd_word)
    );

    lsu_load_align #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_load_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (load_addr),
        .size        (load_size),
        .is_unsigned (load_unsigned),
        .valid       (load_valid),
        .rd_index    (rd_index),
        .rd_en       (rd_en),
        .rd_word     (rd_word),
        .data        (load_data),
        .data_valid  (load_data_valid),
        .misaligned  (load_misaligned)
    );

endmodule

// File: lsu_store_align.sv
// Store aligner; misaligned stores are refused and flagged only while valid is high
`timescale 1ns/1ps

module lsu_store_align
    import lsu_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 4
) (
    input  logic [RAM_ADDR_WIDTH + 2:0] addr,
    input  access_size_t                size,
    input  xlen_t                       wdata,
    input  logic                        valid,
    output logic                        misaligned,
    ram_write_if.source                 wr
);

    logic [2:0] offset;
    logic       bad_align;
    logic [7:0] size_bytes;
    logic [7:0] byte_mask;
    xlen_t      lane_data;

    assign offset    = addr[2:0];
    assign bad_align = is_misaligned(size, offset);

    // Byte lanes touched by the access, before the shift to the offset
    always_comb begin
        case (size)
            SIZE_B:  size_bytes = 8'h01;
            SIZE_H:  size_bytes = 8'h03;
            SIZE_W:  size_bytes = 8'h0f;
            default: size_bytes = 8'hff;
        endcase
    end

    assign byte_mask = size_bytes << offset;

    // Copy the low bytes into every lane so the mask picks the right copy
    always_comb begin
        case (size)
            SIZE_B:  lane_data = {8{wdata[7:0]}};
            SIZE_H:  lane_data = {4{wdata[15:0]}};
            SIZE_W:  lane_data = {2{wdata[31:0]}};
            default: lane_data = wdata;
        endcase
    end

    always_comb begin
        for (int b = 0; b < 8; b++) begin
            wr.mask[8 * b +: 8] = {8{byte_mask[b]}};
        end
    end

    assign misaligned = valid & bad_align;
    assign wr.en      = valid & ~bad_align;
    assign wr.addr    = addr[RAM_ADDR_WIDTH + 2:3];
    assign wr.data    = lane_data;

endmodule

// File: ram_write_if.sv
// RAM write port bundle; no handshake, a write happens on every clk edge with en high
`timescale 1ns/1ps

interface ram_write_if
    import lsu_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 4
);

    // Doubleword index, enable, per-bit mask and data
    logic [RAM_ADDR_WIDTH - 1:0] addr;
    logic                        en;
    bit_mask_t                   mask;
    xlen_t                       data;

    modport source (
        output addr,
        output en,
        output mask,
        output data
    );

    modport sink (
        input addr,
        input en,
        input mask,
        input data
    );

endinterface

// File: stdmacro_dffbe.sv
// Register row with per-bit enable; every bit resets to zero, no other reset value is supported
`timescale 1ns/1ps

module stdmacro_dffbe #(
    parameter int DFF_WIDTH = 1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [DFF_WIDTH - 1:0] en,
    input  logic [DFF_WIDTH - 1:0] d,
    output logic [DFF_WIDTH - 1:0] q
);

    logic [DFF_WIDTH - 1:0] q_next;

    // Enabled bits take d, the others hold
    assign q_next = (d & en) | (q & ~en);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            q <= q_next;
        end
    end

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset; 10 ns period, rst_n low for 3 rising edges, released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: tb_lsu_scratchpad.sv
// Directed testbench for lsu_scratchpad; assumes the default depth of 16 doublewords
`timescale 1ns/1ps

module tb_lsu_scratchpad
    import lsu_pkg::*;
;

    localparam int ADDR_W    = 4;
    localparam int MEM_BYTES = 8 << ADDR_W;
    localparam int LOAD_WAIT = 4;
    // Every store or load takes at most two cycles, plus reset
    localparam int TEST_CYCLES = 2 * (16 + 31 + 21 + 9 + 10 + 200) + 8;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                clk;
    logic                rst_n;
    logic                store_valid;
    logic [ADDR_W + 2:0] store_addr;
    access_size_t        store_size;
    xlen_t               store_data;
    logic                store_misaligned;
    logic                load_valid;
    logic [ADDR_W + 2:0] load_addr;
    access_size_t        load_size;
    logic                load_unsigned;
    xlen_t               load_data;
    logic                load_data_valid;
    logic                load_misaligned;

    logic [7:0] ref_mem [MEM_BYTES];
    int         cycle_count = 0;
    int         test_errors;
    int         total_errors = 0;
    int         total_checks = 0;
    int         tests_run = 0;
    int         tests_bad = 0;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lsu_scratchpad #(
        .RAM_ADDR_WIDTH (ADDR_W)
    ) uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .store_valid      (store_valid),
        .store_addr       (store_addr),
        .store_size       (store_size),
        .store_data       (store_data),
        .store_misaligned (store_misaligned),
        .load_valid       (load_valid),
        .load_addr        (load_addr),
        .load_size        (load_size),
        .load_unsigned    (load_unsigned),
        .load_data        (load_data),
        .load_data_valid  (load_data_valid),
        .load_misaligned  (load_misaligned)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Run stopped after %0d cycles, the tests did not complete", cycle_count);
        $display("tests failed");
        $finish;
    end

    task automatic compare_value(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
        total_checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", sig, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_bad++;
        end
        $display("%-24s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
        test_errors = 0;
    endtask

    // The address must be a multiple of the access width
    function automatic logic breaks_alignment(input int addr, input access_size_t size);
        return (addr % (1 << size)) != 0;
    endfunction

    // Little-endian bytes from the model, then sign or zero fill
    function automatic xlen_t model_load(input int addr, input access_size_t size,
                                         input logic uns);
        int    nbytes;
        xlen_t val;
        nbytes = 1 << size;
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[8 * i +: 8] = ref_mem[addr + i];
        end
        if (!uns && val[8 * nbytes - 1]) begin
            for (int i = 8 * nbytes; i < 64; i++) begin
                val[i] = 1'b1;
            end
        end
        return val;
    endfunction

    task automatic drive_load(input int addr, input access_size_t size, input logic uns);
        load_valid    = 1'b1;
        load_addr     = addr[ADDR_W + 2:0];
        load_size     = size;
        load_unsigned = uns;
    endtask

    task automatic store_and_track(input int addr, input access_size_t size, input xlen_t data);
        logic exp_mis;
        exp_mis     = breaks_alignment(addr, size);
        store_valid = 1'b1;
        store_addr  = addr[ADDR_W + 2:0];
        store_size  = size;
        store_data  = data;
        @(posedge clk);
        compare_value("store_misaligned", store_misaligned, exp_mis);
        @(negedge clk);
        store_valid = 1'b0;
        if (!exp_mis) begin
            for (int i = 0; i < (1 << size); i++) begin
                ref_mem[addr + i] = data[8 * i +: 8];
            end
        end
    endtask

    task automatic load_and_check(input int addr, input access_size_t size, input logic uns);
        xlen_t exp_data;
        logic  exp_mis;
        int    waited;
        exp_mis  = breaks_alignment(addr, size);
        exp_data = exp_mis ? '0 : model_load(addr, size, uns);
        drive_load(addr, size, uns);
        waited = 0;
        do begin
            @(negedge clk);
            load_valid = 1'b0;
            waited++;
        end while (!load_data_valid && waited < LOAD_WAIT);
        assert (load_data_valid && waited == 1) else begin
            $display("Load at %h gave no result one cycle after its strobe", addr);
            test_errors++;
        end
        compare_value("load_data", load_data, exp_data);
        compare_value("load_misaligned", load_misaligned, exp_mis);
    endtask

    task automatic reset_reads_zero();
        compare_value("load_data_valid", load_data_valid, 1'b0);
        for (int i = 0; i < MEM_BYTES / 8; i++) begin
            load_and_check(8 * i, SIZE_D, 1'b0);
        end
        report_test("reset_zero");
    endtask

    task automatic subword_loads();
        store_and_track(40, SIZE_D, 64'hf0e1_d2c3_b4a5_9687);
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                load_and_check(40 + off, access_size_t'(s), 1'b0);
                load_and_check(40 + off, access_size_t'(s), 1'b1);
            end
        end
        report_test("subword_loads");
    endtask

    task automatic partial_stores();
        store_and_track(48, SIZE_D, 64'h0123_4567_89ab_cdef);
        store_and_track(56, SIZE_D, 64'h1122_3344_5566_7788);
        // Upper data bits are set so a wide mask would show up
        store_and_track(49, SIZE_B, 64'hffff_ffff_ffff_ff5a);
        store_and_track(52, SIZE_H, 64'hdead_beef_cafe_a5c3);
        store_and_track(60, SIZE_W, 64'h7777_6666_9abc_def0);
        for (int a = 48; a < 64; a++) begin
            load_and_check(a, SIZE_B, 1'b1);
        end
        report_test("partial_stores");
    endtask

    task automatic misaligned_access();
        store_and_track(64, SIZE_D, 64'h0f1e_2d3c_4b5a_6978);
        store_and_track(65, SIZE_H, 64'hffff_ffff_ffff_ffff);
        store_and_track(66, SIZE_W, 64'hffff_ffff_ffff_ffff);
        store_and_track(68, SIZE_D, 64'hffff_ffff_ffff_ffff);
        load_and_check(64, SIZE_D, 1'b0);
        load_and_check(41, SIZE_H, 1'b0);
        load_and_check(42, SIZE_W, 1'b1);
        load_and_check(44, SIZE_D, 1'b0);
        report_test("misaligned");
    endtask

    task automatic back_to_back_loads();
        xlen_t exp_q [$];
        int    addr;
        for (int k = 0; k < 4; k++) begin
            store_and_track(8 * k, SIZE_D, {$urandom, $urandom});
        end
        // Result k is checked while load k+1 is presented
        for (int k = 0; k <= 4; k++) begin
            if (k > 0) begin
                compare_value("load_data_valid", load_data_valid, 1'b1);
                compare_value("load_data", load_data, exp_q.pop_front());
            end
            if (k < 4) begin
                addr = 8 * k + ((1 << k) & 7);
                exp_q.push_back(model_load(addr, access_size_t'(k), k[0]));
                drive_load(addr, access_size_t'(k), k[0]);
            end else begin
                load_valid = 1'b0;
            end
            @(negedge clk);
        end
        compare_value("load_data_valid", load_data_valid, 1'b0);
        report_test("back_to_back");
    endtask

    task automatic random_traffic();
        int           addr;
        access_size_t size;
        for (int n = 0; n < 200; n++) begin
            size = access_size_t'($urandom_range(3, 0));
            addr = $urandom_range(MEM_BYTES - 1, 0) & ~((1 << size) - 1);
            if ($urandom_range(1, 0) == 1) begin
                store_and_track(addr, size, {$urandom, $urandom});
            end else begin
                load_and_check(addr, size, 1'($urandom_range(1, 0)));
            end
        end
        report_test("random");
    endtask

    initial begin
        void'($urandom(32'h52538241));
        store_valid   = 1'b0;
        store_addr    = '0;
        store_size    = SIZE_B;
        store_data    = '0;
        load_valid    = 1'b0;
        load_addr     = '0;
        load_size     = SIZE_B;
        load_unsigned = 1'b0;
        test_errors   = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        @(posedge rst_n);
        @(negedge clk);
        reset_reads_zero();
        subword_loads();
        partial_stores();
        misaligned_access();
        back_to_back_loads();
        random_traffic();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_bad, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
